/* isb_pkg.sv */
`default_nettype none

package isb_pkg;

    // address and program counter width
    localparam int ADDR_W = 16;

    // structural space: 8 lines of 4 slots
    localparam int SA_W       = 5;
    localparam int SA_SPACE   = 32;
    localparam int SP_SLOTS   = 4;
    localparam int STREAM_LEN = 16;

    // confidence counter
    localparam int CTR_W = 2;
    localparam logic [CTR_W-1:0] CTR_MAX = 2'd3;

    // tag holds the bits above a 32-entry PS index
    localparam int PS_TAG_W = ADDR_W - 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SA_W-1:0]   sa_t;

    typedef struct packed {
        logic                valid;
        logic [PS_TAG_W-1:0] tag;
        sa_t                 sa;
        logic [CTR_W-1:0]    ctr;
    } ps_entry_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_TRAIN,
        S_PREF
    } ctrl_state_e;

    // presence of A and B in the PS map
    typedef enum logic [2:0] {
        TC_SKIP,
        TC_NEW_PAIR,
        TC_ONLY_B,
        TC_ONLY_A,
        TC_BOTH
    } train_case_e;

endpackage

`default_nettype wire

/* isb_ifs.sv */
`default_nettype none

// controller <-> training unit
interface tu_if;
    import isb_pkg::*;

    addr_t lookup_pc;
    logic  hit;
    addr_t last;
    logic  upd_en;
    addr_t upd_pc;
    addr_t upd_last;

    modport ctrl (output lookup_pc, upd_en, upd_pc, upd_last, input hit, last);
    modport tbl  (input lookup_pc, upd_en, upd_pc, upd_last, output hit, last);
endinterface

// controller <-> PS-AMC
// port A writes the previous address, port B the current one
interface ps_if;
    import isb_pkg::*;

    addr_t            addr_a;
    addr_t            addr_b;
    logic             hit_a;
    logic             hit_b;
    ps_entry_t        entry_a;
    ps_entry_t        entry_b;
    logic             wr_a_en;
    addr_t            wr_a_addr;
    sa_t              wr_a_sa;
    logic [CTR_W-1:0] wr_a_ctr;
    logic             wr_b_en;
    addr_t            wr_b_addr;
    sa_t              wr_b_sa;
    logic [CTR_W-1:0] wr_b_ctr;

    modport ctrl (
        output addr_a, addr_b, wr_a_en, wr_a_addr, wr_a_sa, wr_a_ctr,
        output wr_b_en, wr_b_addr, wr_b_sa, wr_b_ctr,
        input  hit_a, entry_a, hit_b, entry_b
    );
    modport tbl (
        input  addr_a, addr_b, wr_a_en, wr_a_addr, wr_a_sa, wr_a_ctr,
        input  wr_b_en, wr_b_addr, wr_b_sa, wr_b_ctr,
        output hit_a, entry_a, hit_b, entry_b
    );
endinterface

// controller <-> SP-AMC
interface sp_if;
    import isb_pkg::*;

    logic  wr0_en;
    sa_t   wr0_sa;
    addr_t wr0_addr;
    logic  wr1_en;
    sa_t   wr1_sa;
    addr_t wr1_addr;
    sa_t   rd_sa;
    logic  rd_valid;
    addr_t rd_addr;

    modport ctrl (output wr0_en, wr0_sa, wr0_addr, wr1_en, wr1_sa, wr1_addr, rd_sa,
                  input rd_valid, rd_addr);
    modport tbl  (input wr0_en, wr0_sa, wr0_addr, wr1_en, wr1_sa, wr1_addr, rd_sa,
                  output rd_valid, rd_addr);
endinterface

`default_nettype wire

/* isb_train_unit.sv */
`default_nettype none

module isb_train_unit #(
    parameter int TU_ENTRIES = 4
) (
    input logic clk,
    input logic rst_n_i,
    tu_if.tbl   tu
);
    import isb_pkg::*;

    localparam int IDX_W = (TU_ENTRIES > 1) ? $clog2(TU_ENTRIES) : 1;
    localparam logic [IDX_W-1:0] OLDEST = IDX_W'(TU_ENTRIES - 1);

    logic [TU_ENTRIES-1:0] valid_q;
    addr_t                 pc_q   [TU_ENTRIES];
    addr_t                 last_q [TU_ENTRIES];
    // ages form a permutation, 0 is most recently used
    logic [IDX_W-1:0]      age_q  [TU_ENTRIES];

    logic             look_hit;
    logic             upd_hit;
    logic             free_found;
    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] upd_idx;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] lru_idx;
    logic [IDX_W-1:0] wr_idx;

    // scan downwards so the lowest matching index wins
    always_comb begin
        look_hit   = 1'b0;
        upd_hit    = 1'b0;
        free_found = 1'b0;
        look_idx   = '0;
        upd_idx    = '0;
        free_idx   = '0;
        lru_idx    = '0;
        for (int i = TU_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && pc_q[i] == tu.lookup_pc) begin
                look_hit = 1'b1;
                look_idx = IDX_W'(i);
            end
            if (valid_q[i] && pc_q[i] == tu.upd_pc) begin
                upd_hit = 1'b1;
                upd_idx = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (age_q[i] == OLDEST) begin
                lru_idx = IDX_W'(i);
            end
        end
    end

    assign wr_idx  = upd_hit ? upd_idx : (free_found ? free_idx : lru_idx);
    assign tu.hit  = look_hit;
    assign tu.last = last_q[look_idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < TU_ENTRIES; i++) begin
                age_q[i] <= IDX_W'(i);
            end
        end else if (tu.upd_en) begin
            valid_q[wr_idx] <= 1'b1;
            // entries younger than the written one age by one
            for (int i = 0; i < TU_ENTRIES; i++) begin
                if (age_q[i] < age_q[wr_idx]) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
            age_q[wr_idx] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (tu.upd_en) begin
            pc_q[wr_idx]   <= tu.upd_pc;
            last_q[wr_idx] <= tu.upd_last;
        end
    end

endmodule

`default_nettype wire

/* isb_ps_amc.sv */
`default_nettype none

module isb_ps_amc #(
    parameter int PS_ENTRIES = 32
) (
    input logic clk,
    input logic rst_n_i,
    ps_if.tbl   ps
);
    import isb_pkg::*;

    localparam int IDX_W = $clog2(PS_ENTRIES);

    ps_entry_t mem_q [PS_ENTRIES];

    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;

    function automatic logic [PS_TAG_W-1:0] tag_of(addr_t a);
        return a[ADDR_W-1 -: PS_TAG_W];
    endfunction

    function automatic ps_entry_t make_entry(addr_t a, sa_t s, logic [CTR_W-1:0] c);
        ps_entry_t e;
        e.valid = 1'b1;
        e.tag   = tag_of(a);
        e.sa    = s;
        e.ctr   = c;
        return e;
    endfunction

    assign idx_a = ps.addr_a[IDX_W-1:0];
    assign idx_b = ps.addr_b[IDX_W-1:0];

    assign ps.entry_a = mem_q[idx_a];
    assign ps.entry_b = mem_q[idx_b];
    assign ps.hit_a   = mem_q[idx_a].valid && mem_q[idx_a].tag == tag_of(ps.addr_a);
    assign ps.hit_b   = mem_q[idx_b].valid && mem_q[idx_b].tag == tag_of(ps.addr_b);

    // B is written last, so it owns the entry when both share an index
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PS_ENTRIES; i++) begin
                mem_q[i].valid <= 1'b0;
            end
        end else begin
            if (ps.wr_a_en) begin
                mem_q[ps.wr_a_addr[IDX_W-1:0]] <= make_entry(ps.wr_a_addr, ps.wr_a_sa,
                                                             ps.wr_a_ctr);
            end
            if (ps.wr_b_en) begin
                mem_q[ps.wr_b_addr[IDX_W-1:0]] <= make_entry(ps.wr_b_addr, ps.wr_b_sa,
                                                             ps.wr_b_ctr);
            end
        end
    end

endmodule

`default_nettype wire

/* isb_sp_amc.sv */
`default_nettype none

module isb_sp_amc (
    input logic clk,
    input logic rst_n_i,
    sp_if.tbl   sp
);
    import isb_pkg::*;

    localparam int SP_LINES = SA_SPACE / SP_SLOTS;
    localparam int SLOT_W   = $clog2(SP_SLOTS);

    // structural address splits into line and slot
    logic [SP_SLOTS-1:0] valid_q [SP_LINES];
    addr_t               pa_q    [SP_LINES][SP_SLOTS];

    logic [SA_W-SLOT_W-1:0] rd_line;
    logic [SLOT_W-1:0]      rd_slot;

    assign rd_line = sp.rd_sa[SA_W-1:SLOT_W];
    assign rd_slot = sp.rd_sa[SLOT_W-1:0];

    assign sp.rd_valid = valid_q[rd_line][rd_slot];
    assign sp.rd_addr  = pa_q[rd_line][rd_slot];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SP_LINES; i++) begin
                valid_q[i] <= '0;
            end
        end else begin
            if (sp.wr0_en) begin
                valid_q[sp.wr0_sa[SA_W-1:SLOT_W]][sp.wr0_sa[SLOT_W-1:0]] <= 1'b1;
            end
            if (sp.wr1_en) begin
                valid_q[sp.wr1_sa[SA_W-1:SLOT_W]][sp.wr1_sa[SLOT_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sp.wr0_en) begin
            pa_q[sp.wr0_sa[SA_W-1:SLOT_W]][sp.wr0_sa[SLOT_W-1:0]] <= sp.wr0_addr;
        end
        if (sp.wr1_en) begin
            pa_q[sp.wr1_sa[SA_W-1:SLOT_W]][sp.wr1_sa[SLOT_W-1:0]] <= sp.wr1_addr;
        end
    end

endmodule

`default_nettype wire

/* isb_ctrl.sv */
`default_nettype none

module isb_ctrl (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           req_valid_i,
    input  isb_pkg::addr_t req_pc_i,
    input  isb_pkg::addr_t req_addr_i,
    output logic           req_ready_o,
    output logic           prefetch_valid_o,
    output isb_pkg::addr_t prefetch_addr_o,
    input  logic           prefetch_ready_i,
    tu_if.ctrl             tu,
    ps_if.ctrl             ps,
    sp_if.ctrl             sp
);
    import isb_pkg::*;

    // one extra bit so that sa+1 and next_sa can reach the end of the space
    typedef logic [SA_W:0] sa_ext_t;
    localparam sa_ext_t SPACE = sa_ext_t'(SA_SPACE);
    localparam sa_ext_t STEP  = sa_ext_t'(STREAM_LEN);

    ctrl_state_e state_q;
    addr_t       pc_q;
    addr_t       addr_q;
    addr_t       pref_addr_q;
    sa_ext_t     next_sa_q;

    train_case_e      tcase;
    logic             train;
    logic             pred;
    sa_ext_t          ns1;
    sa_ext_t          sa_a1;
    sa_ext_t          sa_b;
    sa_ext_t          sa_b1;
    logic [CTR_W-1:0] ctr_dec;
    logic [CTR_W-1:0] ctr_inc;
    logic             a_map_en;
    logic             b_map_en;
    sa_ext_t          b_map_sa;
    logic             b_wb_en;
    logic [CTR_W-1:0] b_wb_ctr;
    logic             advance;

    // previous address of this pc is A, the current one is B
    assign tu.lookup_pc = pc_q;
    assign tu.upd_en    = (state_q == S_TRAIN);
    assign tu.upd_pc    = pc_q;
    assign tu.upd_last  = addr_q;
    assign ps.addr_a    = tu.last;
    assign ps.addr_b    = addr_q;

    assign train   = tu.hit && (tu.last != addr_q);
    assign ns1     = next_sa_q + 1'b1;
    assign sa_a1   = {1'b0, ps.entry_a.sa} + 1'b1;
    assign sa_b    = {1'b0, ps.entry_b.sa};
    assign sa_b1   = sa_b + 1'b1;
    assign ctr_dec = ps.entry_b.ctr - 1'b1;
    assign ctr_inc = (ps.entry_b.ctr == CTR_MAX) ? CTR_MAX : ps.entry_b.ctr + 1'b1;

    always_comb begin
        if (!train) begin
            tcase = TC_SKIP;
        end else begin
            case ({ps.hit_a, ps.hit_b})
                2'b00:   tcase = TC_NEW_PAIR;
                2'b01:   tcase = TC_ONLY_B;
                2'b10:   tcase = TC_ONLY_A;
                default: tcase = TC_BOTH;
            endcase
        end
    end

    // training decisions, all taken from the tables before this edge
    always_comb begin
        a_map_en = 1'b0;
        b_map_en = 1'b0;
        b_map_sa = ns1;
        b_wb_en  = 1'b0;
        b_wb_ctr = ctr_dec;
        advance  = 1'b0;
        if (state_q == S_TRAIN) begin
            case (tcase)
                TC_NEW_PAIR: begin
                    a_map_en = (next_sa_q < SPACE);
                    b_map_en = (ns1 < SPACE);
                    advance  = 1'b1;
                end
                TC_ONLY_B: begin
                    a_map_en = (next_sa_q < SPACE);
                    advance  = 1'b1;
                    // counter spent, B moves behind the new A
                    if (ctr_dec == '0) begin
                        b_map_en = (ns1 < SPACE);
                    end else begin
                        b_wb_en = 1'b1;
                    end
                end
                TC_ONLY_A: begin
                    b_map_en = (sa_a1 < SPACE);
                    b_map_sa = sa_a1;
                end
                TC_BOTH: begin
                    if (sa_b == sa_a1) begin
                        b_wb_en  = 1'b1;
                        b_wb_ctr = ctr_inc;
                    end else if (ctr_dec == '0) begin
                        b_map_en = (sa_a1 < SPACE);
                        b_map_sa = sa_a1;
                    end else begin
                        b_wb_en = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign ps.wr_a_en   = a_map_en;
    assign ps.wr_a_addr = tu.last;
    assign ps.wr_a_sa   = next_sa_q[SA_W-1:0];
    assign ps.wr_a_ctr  = CTR_MAX;
    assign ps.wr_b_en   = b_map_en | b_wb_en;
    assign ps.wr_b_addr = addr_q;
    assign ps.wr_b_sa   = b_map_en ? b_map_sa[SA_W-1:0] : ps.entry_b.sa;
    assign ps.wr_b_ctr  = b_map_en ? CTR_MAX : b_wb_ctr;

    assign sp.wr0_en   = a_map_en;
    assign sp.wr0_sa   = next_sa_q[SA_W-1:0];
    assign sp.wr0_addr = tu.last;
    assign sp.wr1_en   = b_map_en;
    assign sp.wr1_sa   = b_map_sa[SA_W-1:0];
    assign sp.wr1_addr = addr_q;

    // degree 1: the physical address at B's structural successor
    assign sp.rd_sa = sa_b1[SA_W-1:0];
    assign pred     = ps.hit_b && (sa_b1 < SPACE) && sp.rd_valid;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            next_sa_q <= '0;
        end else begin
            if (advance && next_sa_q < SPACE) begin
                next_sa_q <= next_sa_q + STEP;
            end
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= S_TRAIN;
                    end
                end
                S_TRAIN: state_q <= pred ? S_PREF : S_IDLE;
                S_PREF: begin
                    if (prefetch_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_valid_i) begin
            pc_q   <= req_pc_i;
            addr_q <= req_addr_i;
        end
        if (state_q == S_TRAIN) begin
            pref_addr_q <= sp.rd_addr;
        end
    end

    assign req_ready_o      = (state_q == S_IDLE);
    assign prefetch_valid_o = (state_q == S_PREF);
    assign prefetch_addr_o  = pref_addr_q;

endmodule

`default_nettype wire

/* isb_top.sv */
`default_nettype none

module isb_top #(
    parameter int TU_ENTRIES = 4,
    parameter int PS_ENTRIES = 32
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           req_valid_i,
    input  isb_pkg::addr_t req_pc_i,
    input  isb_pkg::addr_t req_addr_i,
    output logic           req_ready_o,
    output logic           prefetch_valid_o,
    output isb_pkg::addr_t prefetch_addr_o,
    input  logic           prefetch_ready_i
);

    tu_if tu_bus ();
    ps_if ps_bus ();
    sp_if sp_bus ();

    isb_ctrl ctrl_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_pc_i         (req_pc_i),
        .req_addr_i       (req_addr_i),
        .req_ready_o      (req_ready_o),
        .prefetch_valid_o (prefetch_valid_o),
        .prefetch_addr_o  (prefetch_addr_o),
        .prefetch_ready_i (prefetch_ready_i),
        .tu               (tu_bus),
        .ps               (ps_bus),
        .sp               (sp_bus)
    );

    // per-pc history
    isb_train_unit #(
        .TU_ENTRIES (TU_ENTRIES)
    ) tu_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .tu      (tu_bus)
    );

    isb_ps_amc #(
        .PS_ENTRIES (PS_ENTRIES)
    ) ps_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ps      (ps_bus)
    );

    isb_sp_amc sp_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .sp      (sp_bus)
    );

endmodule

`default_nettype wire

/* isb_sva.sv */
`default_nettype none

module isb_sva (
    input logic           clk,
    input logic           rst_n_i,
    input logic           req_ready_i,
    input logic           pf_valid_i,
    input isb_pkg::addr_t pf_addr_i,
    input logic           pf_ready_i
);

    // a pending prefetch holds until taken
    pf_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        pf_valid_i && !pf_ready_i |=> pf_valid_i && $stable(pf_addr_i))
    else $error("prefetch output changed before it was taken");

    // no new request while a prefetch waits
    ready_block_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        pf_valid_i |-> !req_ready_i)
    else $error("req_ready_o high while a prefetch is pending");

    pf_reset_a: assert property (@(posedge clk)
        !rst_n_i |-> !pf_valid_i)
    else $error("prefetch_valid_o high during reset");

endmodule

bind isb_top isb_sva sva_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_ready_i (req_ready_o),
    .pf_valid_i  (prefetch_valid_o),
    .pf_addr_i   (prefetch_addr_o),
    .pf_ready_i  (prefetch_ready_i)
);

`default_nettype wire

/* tb_isb.sv */
`default_nettype none

module tb_isb;
    import isb_pkg::*;

    localparam int TU_N    = 4;
    localparam int TU_IW   = 2;
    localparam int PS_N    = 32;
    localparam int N_REQ   = 3000;
    localparam int TIMEOUT = 50;

    logic  clk;
    logic  rst_n_i;
    logic  req_valid_i;
    addr_t req_pc_i;
    addr_t req_addr_i;
    logic  req_ready_o;
    logic  prefetch_valid_o;
    addr_t prefetch_addr_o;
    logic  prefetch_ready_i;

    integer seed;
    int     n_pred;
    int     n_none;

    // reference model of the three tables and the stream pointer
    bit    tu_valid [TU_N];
    addr_t tu_pc    [TU_N];
    addr_t tu_last  [TU_N];
    int    tu_age   [TU_N];
    bit    ps_valid [PS_N];
    addr_t ps_addr  [PS_N];
    int    ps_sa    [PS_N];
    int    ps_ctr   [PS_N];
    bit    sp_valid [SA_SPACE];
    addr_t sp_addr  [SA_SPACE];
    int    next_sa;

    isb_top #(
        .TU_ENTRIES (TU_N),
        .PS_ENTRIES (PS_N)
    ) dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_pc_i         (req_pc_i),
        .req_addr_i       (req_addr_i),
        .req_ready_o      (req_ready_o),
        .prefetch_valid_o (prefetch_valid_o),
        .prefetch_addr_o  (prefetch_addr_o),
        .prefetch_ready_i (prefetch_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // six program counters, forty addresses with PS index conflicts
    function automatic addr_t pc_of(input int k);
        return addr_t'(32'h0100 + 32'h0104 * k);
    endfunction

    function automatic addr_t addr_of(input int k);
        return addr_t'(32'h2000 + 35 * k);
    endfunction

    task automatic model_reset();
        for (int i = 0; i < TU_N; i++) begin
            tu_valid[i] = 1'b0;
            tu_age[i]   = i;
        end
        for (int i = 0; i < PS_N; i++) begin
            ps_valid[i] = 1'b0;
            ps_sa[i]    = 0;
            ps_ctr[i]   = 0;
        end
        for (int i = 0; i < SA_SPACE; i++) begin
            sp_valid[i] = 1'b0;
        end
        next_sa = 0;
    endtask

    function automatic bit ps_hit(input addr_t x);
        return ps_valid[x[4:0]] && ps_addr[x[4:0]] == x;
    endfunction

    task automatic ps_write(input addr_t x, input int s, input int c);
        ps_valid[x[4:0]] = 1'b1;
        ps_addr[x[4:0]]  = x;
        ps_sa[x[4:0]]    = s;
        ps_ctr[x[4:0]]   = c;
    endtask

    // only slots inside the structural space are ever mapped
    task automatic map_addr(input addr_t x, input int s);
        if (s < SA_SPACE) begin
            ps_write(x, s, int'(CTR_MAX));
            sp_valid[SA_W'(s)] = 1'b1;
            sp_addr[SA_W'(s)]  = x;
        end
    endtask

    task automatic advance_stream();
        if (next_sa < SA_SPACE) begin
            next_sa = next_sa + STREAM_LEN;
        end
    endtask

    task automatic model_step(input addr_t pc, input addr_t b, output bit pred,
                              output addr_t pa);
        int               hit_idx;
        int               wr;
        int               old_age;
        int               sa_a;
        int               sa_b;
        int               ctr_b;
        int               base;
        bit               hit_a;
        bit               hit_b;
        addr_t            a;
        logic [TU_IW-1:0] w;
        hit_idx = -1;
        for (int i = TU_N - 1; i >= 0; i--) begin
            if (tu_valid[i] && tu_pc[i] == pc) begin
                hit_idx = i;
            end
        end
        hit_b = ps_hit(b);
        sa_b  = ps_sa[b[4:0]];
        ctr_b = ps_ctr[b[4:0]];
        // prediction sees the tables before this access trains them
        pred = 1'b0;
        pa   = '0;
        if (hit_b && sa_b + 1 < SA_SPACE) begin
            if (sp_valid[SA_W'(sa_b + 1)]) begin
                pred = 1'b1;
                pa   = sp_addr[SA_W'(sa_b + 1)];
            end
        end
        if (hit_idx >= 0 && tu_last[TU_IW'(hit_idx)] != b) begin
            a     = tu_last[TU_IW'(hit_idx)];
            hit_a = ps_hit(a);
            sa_a  = ps_sa[a[4:0]];
            base  = next_sa;
            if (!hit_a && !hit_b) begin
                map_addr(a, base);
                map_addr(b, base + 1);
                advance_stream();
            end else if (!hit_a) begin
                map_addr(a, base);
                advance_stream();
                if (ctr_b == 1) begin
                    map_addr(b, base + 1);
                end else begin
                    ps_write(b, sa_b, ctr_b - 1);
                end
            end else if (!hit_b) begin
                map_addr(b, sa_a + 1);
            end else if (sa_b == sa_a + 1) begin
                ps_write(b, sa_b, (ctr_b < int'(CTR_MAX)) ? ctr_b + 1 : int'(CTR_MAX));
            end else if (ctr_b == 1) begin
                map_addr(b, sa_a + 1);
            end else begin
                ps_write(b, sa_b, ctr_b - 1);
            end
        end
        // training unit: hit, else lowest free entry, else least recently used
        wr = hit_idx;
        if (wr < 0) begin
            for (int i = TU_N - 1; i >= 0; i--) begin
                if (!tu_valid[i]) begin
                    wr = i;
                end
            end
        end
        if (wr < 0) begin
            for (int i = 0; i < TU_N; i++) begin
                if (tu_age[i] == TU_N - 1) begin
                    wr = i;
                end
            end
        end
        w       = TU_IW'(wr);
        old_age = tu_age[w];
        for (int i = 0; i < TU_N; i++) begin
            if (tu_age[i] < old_age) begin
                tu_age[i] = tu_age[i] + 1;
            end
        end
        tu_age[w]   = 0;
        tu_valid[w] = 1'b1;
        tu_pc[w]    = pc;
        tu_last[w]  = b;
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!req_ready_o) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_on_error("Timeout: req_ready_o did not return high");
            end
        end
    endtask

    // holds prefetch_ready_i low at random while offering a competing request
    task automatic hold_prefetch(input addr_t exp_addr);
        int cnt;
        bit take;
        cnt  = 0;
        take = 1'b0;
        while (!take) begin
            take             = ({$random(seed)} % 3 == 0) || (cnt >= 12);
            prefetch_ready_i = take;
            req_valid_i      = !take;
            req_pc_i         = pc_of({$random(seed)} % 6);
            req_addr_i       = addr_of({$random(seed)} % 40);
            @(posedge clk);
            #1;
            cnt++;
            if (!take) begin
                assert (prefetch_valid_o && prefetch_addr_o == exp_addr && !req_ready_o)
                else stop_on_error($sformatf("Mismatch at %0t: stalled prefetch %b %h, ready %b",
                                             $time, prefetch_valid_o, prefetch_addr_o,
                                             req_ready_o));
            end
        end
        prefetch_ready_i = 1'b0;
        assert (!prefetch_valid_o && req_ready_o)
        else stop_on_error($sformatf("Mismatch at %0t: prefetch not released after take",
                                     $time));
    endtask

    task automatic run_request(input addr_t pc, input addr_t addr);
        bit    exp_pred;
        addr_t exp_addr;
        int    edges;
        wait_ready();
        model_step(pc, addr, exp_pred, exp_addr);
        req_valid_i = 1'b1;
        req_pc_i    = pc;
        req_addr_i  = addr;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        edges       = 1;
        while (!prefetch_valid_o && !req_ready_o) begin
            @(posedge clk);
            #1;
            edges++;
            if (edges > TIMEOUT) begin
                stop_on_error("Timeout: no response to an accepted request");
            end
        end
        assert (edges == 2)
        else stop_on_error($sformatf("Mismatch at %0t: response after %0d edges, expected 2",
                                     $time, edges));
        assert (prefetch_valid_o == exp_pred)
        else stop_on_error($sformatf("Mismatch at %0t: prefetch_valid_o %b, expected %b",
                                     $time, prefetch_valid_o, exp_pred));
        if (exp_pred) begin
            assert (prefetch_addr_o == exp_addr)
            else stop_on_error($sformatf("Mismatch at %0t: prefetch_addr_o %h, expected %h",
                                         $time, prefetch_addr_o, exp_addr));
            n_pred++;
            hold_prefetch(exp_addr);
        end else begin
            n_none++;
        end
    endtask

    initial begin
        int gap;
        seed             = 32'h29f8_2e06;
        n_pred           = 0;
        n_none           = 0;
        rst_n_i          = 1'b0;
        req_valid_i      = 1'b0;
        req_pc_i         = '0;
        req_addr_i       = '0;
        prefetch_ready_i = 1'b0;
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        assert (req_ready_o && !prefetch_valid_o)
        else stop_on_error($sformatf("Mismatch at %0t: outputs after reset ready %b valid %b",
                                     $time, req_ready_o, prefetch_valid_o));

        // one pc looping over three addresses builds a stream
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 3; k++) begin
                run_request(pc_of(0), addr_of(k));
            end
        end

        for (int n = 0; n < N_REQ; n++) begin
            gap = {$random(seed)} % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            run_request(pc_of({$random(seed)} % 6), addr_of({$random(seed)} % 40));
        end

        assert (n_pred > 0 && n_none > 0)
        else stop_on_error("The run never produced both a prefetch and an empty response");
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* isb_top.f */
isb_pkg.sv
isb_ifs.sv
isb_train_unit.sv
isb_ps_amc.sv
isb_sp_amc.sv
isb_ctrl.sv
isb_top.sv
isb_sva.sv
tb_isb.sv

/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP       := tb_isb
FILELIST  := isb_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
